// File: src.f
+incdir+sim
verilog/dec_pkg.sv
verilog/dec_slot_decode.sv
verilog/dec_gpr_file.sv
verilog/dec_issue_ctl.sv
verilog/dec.sv
sim/tb_dec.sv

// File: Makefile
# Verilator flow for the decode front end
# make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= tb_dec
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_STR  ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail, not the exit status of the run
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_dec_ref.svh
// decode reference model
// expected immediate, register fields, legality and issue pair, taken from
// the RV32I encoding and the in-order dual-issue and load-use rules
`ifndef TB_DEC_REF_SVH
`define TB_DEC_REF_SVH

// immediate by format and zero for op and unknown words
function automatic logic [31:0] immed_of(input logic [31:0] w);
   case (w[6:0])
      OPC_LOAD, OPC_OP_IMM, OPC_JALR: immed_of = {{20{w[31]}}, w[31:20]};
      OPC_STORE:          immed_of = {{20{w[31]}}, w[31:25], w[11:7]};
      OPC_BRANCH:         immed_of = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      OPC_LUI, OPC_AUIPC: immed_of = {w[31:12], 12'h000};
      OPC_JAL:            immed_of = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default:            immed_of = '0;
   endcase
endfunction

// register fields with en as {rs1_en, rs2_en, rd_en}
function automatic void fields_of(input logic [31:0] w,
                                  output logic [4:0] rs1, output logic [4:0] rs2,
                                  output logic [4:0] rd, output logic [2:0] en,
                                  output logic is_load, output logic legal);
   instr_u v;
   v       = w;
   rs1     = v.r.rs1;
   rs2     = v.r.rs2;
   rd      = v.r.rd;
   is_load = (v.r.opcode == OPC_LOAD);
   legal   = 1'b1;
   case (v.r.opcode)
      OPC_LOAD, OPC_OP_IMM, OPC_JALR: en = 3'b101;    // one source and rd
      OPC_STORE, OPC_BRANCH:          en = 3'b110;    // two sources and no rd
      OPC_LUI, OPC_AUIPC, OPC_JAL:    en = 3'b001;    // rd only
      OPC_OP: begin
         legal = (v.r.funct7 == 7'h00) || (v.r.funct7 == 7'h20);
         en    = legal ? 3'b111 : 3'b000;
      end
      default: begin
         legal = 1'b0;
         en    = 3'b000;
      end
   endcase
endfunction

// an enabled source of the word names register r
function automatic logic reads_reg(input logic [31:0] w, input logic [4:0] r);
   logic [4:0] s1, s2, d;
   logic [2:0] en;
   logic       ld, lg;
   fields_of(w, s1, s2, d, en, ld, lg);
   reads_reg = (en[2] && (s1 == r)) || (en[1] && (s2 == r));
endfunction

// issue pair for the current slots and the next e1 load record
function automatic void issue_pair(input logic v0, input logic [31:0] w0,
                                   input logic v1, input logic [31:0] w1,
                                   input logic e1_v, input logic [4:0] e1_r,
                                   output logic i0, output logic i1,
                                   output logic nxt_v, output logic [4:0] nxt_r);
   logic [4:0] s1, s2, d0, d1;
   logic [2:0] en0, en1;
   logic       ld0, ld1, lg0, lg1, lu0, lu1;
   fields_of(w0, s1, s2, d0, en0, ld0, lg0);
   fields_of(w1, s1, s2, d1, en1, ld1, lg1);
   lu0   = e1_v && (e1_r != 5'd0) && reads_reg(w0, e1_r);
   lu1   = e1_v && (e1_r != 5'd0) && reads_reg(w1, e1_r);
   i0    = v0 && lg0 && !lu0;
   i1    = i0 && v1 && lg1 && !lu1 && !(en0[0] && (d0 != 5'd0) && reads_reg(w1, d0));
   nxt_v = (i0 && ld0) || (i1 && ld1);
   nxt_r = (i1 && ld1) ? d1 : ((i0 && ld0) ? d0 : 5'd0);    // younger load kept
endfunction

`endif

// File: sim/tb_dec.sv
// testbench for the dual-issue decode front end
// random and directed slots and write-backs, checked one step after each
// edge against the reference decode, a register model and an e1 load model
`timescale 1ns/1ns
module tb_dec
   import dec_pkg::*;
();

   logic        clk, rst_n;
   logic        ifu_i0_valid, ifu_i1_valid;
   logic [31:0] ifu_i0_instr, ifu_i1_instr;
   logic        wb0_wen, wb1_wen;
   logic [4:0]  wb0_waddr, wb1_waddr;
   logic [31:0] wb0_wdata, wb1_wdata;
   logic        dec_i0_decode_d, dec_i1_decode_d, dec_illegal_d;
   logic [31:0] dec_i0_immed_d, dec_i1_immed_d;
   logic [31:0] gpr_i0_rs1_d, gpr_i0_rs2_d, gpr_i1_rs1_d, gpr_i1_rs2_d;

   logic [31:0] gpr_model [0:31];               // architectural state copy
   logic        e1_valid;                       // e1 load record copy
   logic [4:0]  e1_rd;
   logic        check_on = 1'b0;
   integer      seed = 10119;
   string       test_name = "reset";
   int          test_checks, test_errors, total_checks, total_errors;
   int          tests_run, tests_failed;
   logic [6:0]  legal_opc [9] = '{OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_LUI,
                                  OPC_AUIPC, OPC_BRANCH, OPC_JAL, OPC_JALR};

   `include "tb_dec_ref.svh"

   dec u_dec (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;                        // 4 ns period

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      test_checks++;
      total_checks++;
      if (actual !== expected) begin
         test_errors++;
         total_errors++;
         $display("Mismatch %s %s: expected %h actual %h", test_name, name, expected, actual);
      end
   endtask

   task automatic timeout_stop(input string what);
      $display("%s timed out", what);
      $display("Test failures found");
      $finish;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic finish_test();
      @(negedge clk);                           // comparing process done with the cycle
      tests_run++;
      if (test_errors != 0) tests_failed++;
      $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
   endtask

   // new slot levels on the rising edge and write-backs off until set_writeback
   task automatic drive_cycle(input logic v0, input logic [31:0] w0,
                              input logic v1, input logic [31:0] w1);
      @(posedge clk);
      ifu_i0_valid <= v0;
      ifu_i0_instr <= w0;
      ifu_i1_valid <= v1;
      ifu_i1_instr <= w1;
      wb0_wen      <= 1'b0;
      wb1_wen      <= 1'b0;
   endtask

   task automatic set_writeback(input logic en0, input logic [4:0] a0, input logic [31:0] d0,
                                input logic en1, input logic [4:0] a1, input logic [31:0] d1);
      wb0_wen   <= en0;
      wb0_waddr <= a0;
      wb0_wdata <= d0;
      wb1_wen   <= en1;
      wb1_waddr <= a1;
      wb1_wdata <= d1;
   endtask

   task automatic expect_strobes(input string what, input logic e0, input logic e1);
      #1;
      check_value({what, " i0"}, 32'(e0), 32'(dec_i0_decode_d));
      check_value({what, " i1"}, 32'(e1), 32'(dec_i1_decode_d));
   endtask

   // count edges while fetch holds slot 0 until it issues
   task automatic wait_slot0_issue(input int limit, output int cycles);
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > limit) timeout_stop("wait for slot 0 issue");
      end while (dec_i0_decode_d !== 1'b1);
   endtask

   function automatic logic [31:0] op_add(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      op_add = {7'h00, rs2, rs1, 3'b000, rd, OPC_OP};
   endfunction

   function automatic logic [31:0] op_lw(input logic [4:0] rd, input logic [4:0] rs1);
      op_lw = {12'h000, rs1, 3'b010, rd, OPC_LOAD};
   endfunction

   // random word of a legal opcode or now and then a reserved funct7 or opcode
   function automatic logic [31:0] rand_instr(input logic with_illegal);
      logic [31:0] w, r;
      logic [3:0]  pick;
      w    = $random(seed);
      r    = {$random(seed)} % (with_illegal ? 32'd11 : 32'd9);
      pick = r[3:0];
      if (pick < 4'd9) begin
         w[6:0] = legal_opc[pick];
         if (w[6:0] == OPC_OP)
            w[31:25] = {1'b0, w[30], 5'b00000};      // add or sub class
      end else if (pick == 4'd9) begin
         w[6:0] = OPC_OP;                           // raw funct7
      end else begin
         w[6:0] = w[7] ? 7'b0001111 : 7'b1110011;   // fence or system
      end
      return w;
   endfunction

   // squeeze register numbers into x0..x3 so hazards show up often
   function automatic logic [31:0] narrow_regs(input logic [31:0] w);
      narrow_regs        = w;
      narrow_regs[24:22] = 3'b000;
      narrow_regs[19:17] = 3'b000;
      narrow_regs[11:9]  = 3'b000;
   endfunction

   //***************************************************************************
   // comparing process
   //***************************************************************************
   initial begin
      logic [4:0] s1, s2, d, nr;
      logic [2:0] en;
      logic       ld, lg, x0, x1, nv;
      forever begin
         @(posedge clk);                            // pre-edge inputs advance the models
         issue_pair(ifu_i0_valid, ifu_i0_instr, ifu_i1_valid, ifu_i1_instr,
                    e1_valid, e1_rd, x0, x1, nv, nr);
         if (rst_n !== 1'b1) begin
            e1_valid = 1'b0;
            for (int j = 0; j < NUM_GPR; j++)
               gpr_model[j] = '0;
         end else begin
            e1_valid = nv;
            e1_rd    = nr;
            if (wb0_wen && (wb0_waddr != 5'd0)) gpr_model[wb0_waddr] = wb0_wdata;
            if (wb1_wen && (wb1_waddr != 5'd0)) gpr_model[wb1_waddr] = wb1_wdata;
         end
         #1;
         if (check_on) begin
            issue_pair(ifu_i0_valid, ifu_i0_instr, ifu_i1_valid, ifu_i1_instr,
                       e1_valid, e1_rd, x0, x1, nv, nr);
            check_value("i0 decode", 32'(x0), 32'(dec_i0_decode_d));
            check_value("i1 decode", 32'(x1), 32'(dec_i1_decode_d));
            fields_of(ifu_i0_instr, s1, s2, d, en, ld, lg);
            check_value("illegal", 32'(ifu_i0_valid & ~lg), 32'(dec_illegal_d));
            check_value("i0 immed", immed_of(ifu_i0_instr), dec_i0_immed_d);
            check_value("i0 rs1 data", gpr_model[s1], gpr_i0_rs1_d);
            check_value("i0 rs2 data", gpr_model[s2], gpr_i0_rs2_d);
            fields_of(ifu_i1_instr, s1, s2, d, en, ld, lg);
            check_value("i1 immed", immed_of(ifu_i1_instr), dec_i1_immed_d);
            check_value("i1 rs1 data", gpr_model[s1], gpr_i1_rs1_d);
            check_value("i1 rs2 data", gpr_model[s2], gpr_i1_rs2_d);
         end
      end
   end

   //***************************************************************************
   // test sequence
   //***************************************************************************
   initial begin
      int          n, cycles;
      logic [31:0] r;
      logic [4:0]  a, pa0, pa1;
      rst_n        = 1'b0;
      ifu_i0_valid = 1'b0;
      ifu_i1_valid = 1'b0;
      ifu_i0_instr = '0;
      ifu_i1_instr = '0;
      wb0_wen      = 1'b0;
      wb1_wen      = 1'b0;
      wb0_waddr    = '0;
      wb1_waddr    = '0;
      wb0_wdata    = '0;
      wb1_wdata    = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      n = 0;
      while (rst_n !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > 4) timeout_stop("wait for reset release");
      end
      check_on = 1'b1;

      start_test("reset_idle");                     // strobes quiet with valids low
      repeat (3) begin
         drive_cycle(1'b0, rand_instr(1'b0), 1'b0, rand_instr(1'b0));
         expect_strobes("idle", 1'b0, 1'b0);
      end
      finish_test();

      start_test("gpr_file");                       // reads name last cycle's writes
      pa0 = 5'd0;
      pa1 = 5'd0;
      for (n = 0; n < 40; n++) begin
         r = $random(seed);
         a = (n % 5 == 0) ? 5'd0 : r[24:20];
         drive_cycle(1'b0, op_add(5'd0, pa0, pa1), 1'b0, op_add(5'd0, pa1, pa0));
         set_writeback(r[25], a, $random(seed), r[26], (n % 4 == 0) ? a : r[31:27],
                       $random(seed));
         pa0 = a;
         pa1 = (n % 4 == 0) ? a : r[31:27];
      end
      drive_cycle(1'b0, op_add(5'd0, pa0, pa1), 1'b0, op_add(5'd0, pa1, pa0));
      set_writeback(1'b1, 5'd7, 32'h1111_aaaa, 1'b1, 5'd7, 32'h2222_bbbb);
      drive_cycle(1'b0, op_add(5'd0, 5'd7, 5'd0), 1'b0, op_add(5'd0, 5'd0, 5'd7));
      #1;
      check_value("port 1 wins", 32'h2222_bbbb, gpr_i0_rs1_d);
      check_value("x0 reads zero", 32'h0, gpr_i0_rs2_d);
      finish_test();

      start_test("immediates");
      for (n = 0; n < 60; n++) begin
         r = $random(seed);
         drive_cycle(r[0], rand_instr(1'b0), r[1], rand_instr(1'b0));
      end
      finish_test();

      start_test("dual_issue");
      drive_cycle(1'b0, '0, 1'b0, '0);              // empty e1
      drive_cycle(1'b1, op_add(5'd3, 5'd1, 5'd2), 1'b1, op_add(5'd6, 5'd4, 5'd5));
      expect_strobes("independent", 1'b1, 1'b1);
      drive_cycle(1'b1, op_add(5'd3, 5'd1, 5'd2), 1'b1, op_add(5'd7, 5'd3, 5'd4));
      expect_strobes("raw on x3", 1'b1, 1'b0);
      drive_cycle(1'b1, op_add(5'd0, 5'd1, 5'd2), 1'b1, op_add(5'd7, 5'd0, 5'd4));
      expect_strobes("raw on x0", 1'b1, 1'b1);
      for (n = 0; n < 80; n++) begin
         r = $random(seed);
         drive_cycle(r[0] | r[1], narrow_regs(rand_instr(1'b1)),
                     r[2], narrow_regs(rand_instr(1'b1)));
      end
      finish_test();

      start_test("load_use");
      drive_cycle(1'b0, '0, 1'b0, '0);
      drive_cycle(1'b1, op_lw(5'd5, 5'd1), 1'b0, '0);
      expect_strobes("load", 1'b1, 1'b0);
      drive_cycle(1'b1, op_add(5'd6, 5'd5, 5'd2), 1'b0, '0);
      expect_strobes("stall", 1'b0, 1'b0);
      wait_slot0_issue(4, cycles);
      check_value("stall length", 32'd1, 32'(cycles));
      drive_cycle(1'b0, '0, 1'b0, '0);
      drive_cycle(1'b1, op_lw(5'd5, 5'd1), 1'b1, op_lw(5'd9, 5'd1));
      expect_strobes("two loads", 1'b1, 1'b1);
      drive_cycle(1'b1, op_add(5'd6, 5'd5, 5'd2), 1'b1, op_add(5'd7, 5'd9, 5'd2));
      expect_strobes("younger load kept", 1'b1, 1'b0);
      finish_test();

      start_test("illegal_invalid");
      drive_cycle(1'b0, '0, 1'b0, '0);
      drive_cycle(1'b1, 32'hffff_ffff, 1'b1, op_add(5'd3, 5'd1, 5'd2));
      expect_strobes("illegal slot 0", 1'b0, 1'b0);
      check_value("illegal flag", 32'd1, 32'(dec_illegal_d));
      drive_cycle(1'b0, op_add(5'd3, 5'd1, 5'd2), 1'b1, op_add(5'd6, 5'd4, 5'd5));
      expect_strobes("invalid slot 0", 1'b0, 1'b0);
      drive_cycle(1'b0, 32'hffff_ffff, 1'b0, '0);   // illegal word but not valid
      #1;
      check_value("no illegal flag", 32'd0, 32'(dec_illegal_d));
      drive_cycle(1'b0, '0, 1'b0, '0);
      #1;
      finish_test();

      $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
               tests_run, tests_failed, total_checks, total_errors);
      if (total_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: verilog/dec.sv
// decode unit front end
// two RV32I slot decoders, a shared 4-read/2-write register file and the
// issue controller that turns both decodes into issue strobes
`timescale 1ns/1ns
module dec
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,

   input  logic                  ifu_i0_valid,     // fetch slot levels
   input  logic                  ifu_i1_valid,
   input  logic [XLEN-1:0]       ifu_i0_instr,
   input  logic [XLEN-1:0]       ifu_i1_instr,

   input  logic                  wb0_wen,          // write-back, older
   input  logic [REG_ADDR_W-1:0] wb0_waddr,
   input  logic [XLEN-1:0]       wb0_wdata,
   input  logic                  wb1_wen,          // write-back, younger
   input  logic [REG_ADDR_W-1:0] wb1_waddr,
   input  logic [XLEN-1:0]       wb1_wdata,

   output logic                  dec_i0_decode_d,  // issue strobes
   output logic                  dec_i1_decode_d,
   output logic                  dec_illegal_d,
   output logic [XLEN-1:0]       dec_i0_immed_d,
   output logic [XLEN-1:0]       dec_i1_immed_d,
   output logic [XLEN-1:0]       gpr_i0_rs1_d,     // operand read data
   output logic [XLEN-1:0]       gpr_i0_rs2_d,
   output logic [XLEN-1:0]       gpr_i1_rs1_d,
   output logic [XLEN-1:0]       gpr_i1_rs2_d
);

   logic [REG_ADDR_W-1:0] i0_rs1, i0_rs2, i0_rd;    // slot 0 fields
   logic [REG_ADDR_W-1:0] i1_rs1, i1_rs2, i1_rd;    // slot 1 fields
   logic                  i0_rs1_en, i0_rs2_en, i0_rd_en;
   logic                  i1_rs1_en, i1_rs2_en, i1_rd_en;
   logic                  i0_is_load, i1_is_load;
   logic                  i0_legal, i1_legal;

   //**************************************************************************
   // slot decoders
   //**************************************************************************
   dec_slot_decode u_i0_decode (
      .instr(ifu_i0_instr), .rs1(i0_rs1), .rs2(i0_rs2), .rd(i0_rd),
      .rs1_en(i0_rs1_en), .rs2_en(i0_rs2_en), .rd_en(i0_rd_en),
      .immed(dec_i0_immed_d), .is_load(i0_is_load), .legal(i0_legal)
   );

   dec_slot_decode u_i1_decode (
      .instr(ifu_i1_instr), .rs1(i1_rs1), .rs2(i1_rs2), .rd(i1_rd),
      .rs1_en(i1_rs1_en), .rs2_en(i1_rs2_en), .rd_en(i1_rd_en),
      .immed(dec_i1_immed_d), .is_load(i1_is_load), .legal(i1_legal)
   );

   // register file, read addresses straight from the decoders
   dec_gpr_file u_gpr (
      .clk(clk), .rst_n(rst_n),
      .raddr0(i0_rs1), .raddr1(i0_rs2), .raddr2(i1_rs1), .raddr3(i1_rs2),
      .wen0(wb0_wen), .waddr0(wb0_waddr), .wd0(wb0_wdata),
      .wen1(wb1_wen), .waddr1(wb1_waddr), .wd1(wb1_wdata),
      .rd0(gpr_i0_rs1_d), .rd1(gpr_i0_rs2_d), .rd2(gpr_i1_rs1_d), .rd3(gpr_i1_rs2_d)
   );

   // issue rules and e1 load record
   dec_issue_ctl u_issue (
      .clk(clk), .rst_n(rst_n),
      .i0_valid(ifu_i0_valid), .i1_valid(ifu_i1_valid),
      .i0_legal(i0_legal), .i1_legal(i1_legal),
      .i0_is_load(i0_is_load), .i1_is_load(i1_is_load),
      .i0_rs1(i0_rs1), .i0_rs2(i0_rs2), .i0_rd(i0_rd),
      .i1_rs1(i1_rs1), .i1_rs2(i1_rs2), .i1_rd(i1_rd),
      .i0_rs1_en(i0_rs1_en), .i0_rs2_en(i0_rs2_en), .i0_rd_en(i0_rd_en),
      .i1_rs1_en(i1_rs1_en), .i1_rs2_en(i1_rs2_en), .i1_rd_en(i1_rd_en),
      .i0_decode(dec_i0_decode_d), .i1_decode(dec_i1_decode_d),
      .illegal(dec_illegal_d)
   );

endmodule

// File: verilog/dec_issue_ctl.sv
// issue controller
// in-order dual-issue and load-use rules over both slot decodes,
// with a one-stage e1 record of the last issued load
`timescale 1ns/1ns
module dec_issue_ctl
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,

   input  logic                  i0_valid,     // fetch slot 0 held
   input  logic                  i1_valid,     // fetch slot 1 held
   input  logic                  i0_legal,
   input  logic                  i1_legal,
   input  logic                  i0_is_load,
   input  logic                  i1_is_load,

   input  logic [REG_ADDR_W-1:0] i0_rs1,
   input  logic [REG_ADDR_W-1:0] i0_rs2,
   input  logic [REG_ADDR_W-1:0] i0_rd,
   input  logic [REG_ADDR_W-1:0] i1_rs1,
   input  logic [REG_ADDR_W-1:0] i1_rs2,
   input  logic [REG_ADDR_W-1:0] i1_rd,

   input  logic                  i0_rs1_en,
   input  logic                  i0_rs2_en,
   input  logic                  i0_rd_en,
   input  logic                  i1_rs1_en,
   input  logic                  i1_rs2_en,
   input  logic                  i1_rd_en,

   output logic                  i0_decode,    // slot 0 issues this cycle
   output logic                  i1_decode,    // slot 1 issues this cycle
   output logic                  illegal       // valid illegal word in slot 0
);

   logic                  e1_load_valid;        // load sitting in e1
   logic [REG_ADDR_W-1:0] e1_load_rd;           // its destination
   logic                  e1_rd_nz;             // e1 load writes a real register
   logic                  i0_load_use;          // slot 0 needs e1 load data
   logic                  i1_load_use;
   logic                  i0_rd_nz;             // slot 0 writes a real register
   logic                  i1_raw;               // slot 1 reads slot 0's rd

   //**************************************************************************
   // hazard detect
   //**************************************************************************
   assign e1_rd_nz = e1_load_valid & (e1_load_rd != '0);

   assign i0_load_use = e1_rd_nz & ((i0_rs1_en & (i0_rs1 == e1_load_rd)) |
                                    (i0_rs2_en & (i0_rs2 == e1_load_rd)));

   assign i1_load_use = e1_rd_nz & ((i1_rs1_en & (i1_rs1 == e1_load_rd)) |
                                    (i1_rs2_en & (i1_rs2 == e1_load_rd)));

   assign i0_rd_nz = i0_rd_en & (i0_rd != '0);  // x0 dependence never blocks

   assign i1_raw = i0_rd_nz & ((i1_rs1_en & (i1_rs1 == i0_rd)) |
                               (i1_rs2_en & (i1_rs2 == i0_rd)));

   // issue strobes, slot 1 never passes slot 0
   assign i0_decode = i0_valid & i0_legal & ~i0_load_use;
   assign i1_decode = i0_decode & i1_valid & i1_legal & ~i1_load_use & ~i1_raw;

   assign illegal = i0_valid & ~i0_legal;       // holds while fetch holds it

   //**************************************************************************
   // e1 load record, replaced every edge
   //**************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         e1_load_valid <= 1'b0;
      end else begin
         e1_load_valid <= (i0_decode & i0_is_load) | (i1_decode & i1_is_load);
      end
   end

   always_ff @(posedge clk) begin
      if (i1_decode & i1_is_load) begin
         e1_load_rd <= i1_rd;                       // younger load wins
      end else if (i0_decode & i0_is_load) begin
         e1_load_rd <= i0_rd;
      end
   end

endmodule

// File: verilog/dec_gpr_file.sv
// general-purpose register file
// 32 x 32-bit, four combinational read ports and two write-back ports,
// x0 reads zero, port 1 wins a same-register write
`timescale 1ns/1ns
module dec_gpr_file
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,         // async, active low

   input  logic [REG_ADDR_W-1:0] raddr0,        // i0 rs1
   input  logic [REG_ADDR_W-1:0] raddr1,        // i0 rs2
   input  logic [REG_ADDR_W-1:0] raddr2,        // i1 rs1
   input  logic [REG_ADDR_W-1:0] raddr3,        // i1 rs2

   input  logic                  wen0,          // older write-back
   input  logic [REG_ADDR_W-1:0] waddr0,
   input  logic [XLEN-1:0]       wd0,
   input  logic                  wen1,          // younger write-back
   input  logic [REG_ADDR_W-1:0] waddr1,
   input  logic [XLEN-1:0]       wd1,

   output logic [XLEN-1:0]       rd0,
   output logic [XLEN-1:0]       rd1,
   output logic [XLEN-1:0]       rd2,
   output logic [XLEN-1:0]       rd3
);

   logic [XLEN-1:0] gpr [1:NUM_GPR-1];          // x1 .. x31, no x0 storage

   //**************************************************************************
   // write ports
   //**************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int j = 1; j < NUM_GPR; j++) begin
            gpr[j] <= '0;                           // architectural reset to zero
         end
      end else begin
         if (wen0 && (waddr0 != '0)) begin
            gpr[waddr0] <= wd0;
         end
         if (wen1 && (waddr1 != '0)) begin
            gpr[waddr1] <= wd1;                     // later nba, younger slot wins
         end
      end
   end

   //**************************************************************************
   // read ports, old value on a same-cycle write
   //**************************************************************************
   function automatic logic [XLEN-1:0] read_gpr(input logic [REG_ADDR_W-1:0] addr);
      read_gpr = (addr == '0) ? '0 : gpr[addr]; // x0 hardwired
   endfunction

   assign rd0 = read_gpr(raddr0);
   assign rd1 = read_gpr(raddr1);
   assign rd2 = read_gpr(raddr2);
   assign rd3 = read_gpr(raddr3);

endmodule

// File: verilog/dec_slot_decode.sv
// slot decoder
// decodes one 32-bit RV32I word into register numbers and enables,
// the sign-extended immediate, a load flag and a legal flag
`timescale 1ns/1ns
module dec_slot_decode
   import dec_pkg::*;
(
   input  logic [XLEN-1:0]       instr,        // word from fetch

   output logic [REG_ADDR_W-1:0] rs1,          // source 1 number
   output logic [REG_ADDR_W-1:0] rs2,          // source 2 number
   output logic [REG_ADDR_W-1:0] rd,           // destination number
   output logic                  rs1_en,       // rs1 is read
   output logic                  rs2_en,       // rs2 is read
   output logic                  rd_en,        // rd is written
   output logic [XLEN-1:0]       immed,        // sign-extended immediate
   output logic                  is_load,      // load class
   output logic                  legal         // known RV32I encoding
);

   instr_u          iw;                         // word seen through both views

   logic [XLEN-1:0] imm_i;                      // loads, op-imm, jalr
   logic [XLEN-1:0] imm_s;                      // stores
   logic [XLEN-1:0] imm_b;                      // branches
   logic [XLEN-1:0] imm_u;                      // lui, auipc
   logic [XLEN-1:0] imm_j;                      // jal

   assign iw = instr;

   // register numbers sit at fixed positions in every format
   assign rs1 = iw.r.rs1;
   assign rs2 = iw.r.rs2;
   assign rd  = iw.r.rd;

   //**************************************************************************
   // immediate formats
   //**************************************************************************
   assign imm_i = {{20{iw.r.funct7[6]}}, iw.r.funct7, iw.r.rs2};        // imm[11:0]

   assign imm_s = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};     // split imm

   assign imm_b = {{20{iw.s.imm_hi[6]}},            // imm[31:12] sign
                   iw.s.imm_lo[0],                  // imm[11]
                   iw.s.imm_hi[5:0],                // imm[10:5]
                   iw.s.imm_lo[4:1],                // imm[4:1]
                   1'b0};                           // halfword aligned

   assign imm_u = {iw.r.funct7, iw.r.rs2, iw.r.rs1, iw.r.funct3, 12'b0}; // upper 20

   assign imm_j = {{12{iw.r.funct7[6]}},            // imm[31:20] sign
                   iw.r.rs1, iw.r.funct3,           // imm[19:12]
                   iw.r.rs2[0],                     // imm[11]
                   iw.r.funct7[5:0],                // imm[10:5]
                   iw.r.rs2[4:1],                   // imm[4:1]
                   1'b0};

   //**************************************************************************
   // opcode decode
   //**************************************************************************
   always_comb begin
      legal   = 1'b1;                               // cleared on unknown words
      rs1_en  = 1'b0;
      rs2_en  = 1'b0;
      rd_en   = 1'b0;
      is_load = 1'b0;
      immed   = '0;
      case (iw.r.opcode)
         OPC_LOAD: begin
            rs1_en  = 1'b1;                         // base address
            rd_en   = 1'b1;
            is_load = 1'b1;
            immed   = imm_i;                        // address offset
         end
         OPC_STORE: begin
            rs1_en  = 1'b1;                         // base
            rs2_en  = 1'b1;                         // store data
            immed   = imm_s;
         end
         OPC_OP_IMM: begin
            rs1_en  = 1'b1;
            rd_en   = 1'b1;
            immed   = imm_i;                        // shamt rides in imm[4:0]
         end
         OPC_OP: begin
            if ((iw.r.funct7 == F7_BASE) || (iw.r.funct7 == F7_ALT)) begin
               rs1_en = 1'b1;
               rs2_en = 1'b1;
               rd_en  = 1'b1;
            end else begin
               legal  = 1'b0;                       // m-ext or reserved funct7
            end
         end
         OPC_LUI, OPC_AUIPC: begin
            rd_en   = 1'b1;
            immed   = imm_u;
         end
         OPC_BRANCH: begin
            rs1_en  = 1'b1;                         // compare operands
            rs2_en  = 1'b1;
            immed   = imm_b;                        // pc relative offset
         end
         OPC_JAL: begin
            rd_en   = 1'b1;                         // link register
            immed   = imm_j;
         end
         OPC_JALR: begin
            rs1_en  = 1'b1;
            rd_en   = 1'b1;
            immed   = imm_i;
         end
         default: begin
            legal   = 1'b0;                         // unknown major opcode
         end
      endcase
   end

endmodule

// File: verilog/dec_pkg.sv
// decode package
// RV32I major opcodes, field widths and the two-view instruction word
// shared by the slot decoders, the register file and the issue controller
package dec_pkg;

   //**************************************************************************
   // widths fixed by the ISA
   //**************************************************************************
   localparam int XLEN       = 32;              // data path width
   localparam int REG_ADDR_W = 5;               // register number
   localparam int NUM_GPR    = 32;              // x0 hardwired to zero
   localparam int OPC_W      = 7;               // major opcode
   localparam int FUNCT3_W   = 3;
   localparam int FUNCT7_W   = 7;

   //**************************************************************************
   // major opcodes, bits [6:0]
   //**************************************************************************
   localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;   // lb/lh/lw/lbu/lhu
   localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;   // sb/sh/sw
   localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;   // addi .. srai
   localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;   // reg-reg alu
   localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
   localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;   // beq .. bgeu
   localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
   localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;

   // funct7 values accepted on OP
   localparam logic [FUNCT7_W-1:0] F7_BASE = 7'h00;     // add, sll, slt ..
   localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'h20;     // sub, sra

   //**************************************************************************
   // instruction word, two views of the same 32 bits
   //**************************************************************************
   // r view covers R, I, U and J formats by field position
   // s view covers S and B, where the immediate is split around rs1/rs2
   typedef union packed {
      struct packed {
         logic [FUNCT7_W-1:0]   funct7;         // [31:25]
         logic [REG_ADDR_W-1:0] rs2;            // [24:20]
         logic [REG_ADDR_W-1:0] rs1;            // [19:15]
         logic [FUNCT3_W-1:0]   funct3;         // [14:12]
         logic [REG_ADDR_W-1:0] rd;             // [11:7]
         logic [OPC_W-1:0]      opcode;         // [6:0]
      } r;
      struct packed {
         logic [6:0]            imm_hi;         // imm[11:5], b: imm[12|10:5]
         logic [REG_ADDR_W-1:0] rs2;
         logic [REG_ADDR_W-1:0] rs1;
         logic [FUNCT3_W-1:0]   funct3;
         logic [4:0]            imm_lo;         // imm[4:0], b: imm[4:1|11]
         logic [OPC_W-1:0]      opcode;
      } s;
   } instr_u;

endpackage
